/* la_decode_pkg.sv */
// LA32 integer subset only; CSR, TLB, cache, barrier, counter, ll/sc and trap encodings are not listed
package la_decode_pkg;

    localparam int inst_w = 32;

    typedef logic [4:0] reg_idx_t;

    typedef struct packed {
        logic [inst_w-1:0] pc;
        logic [inst_w-1:0] inst;
    } fetch_pkt_t;

    typedef enum logic [5:0] {
        op_invalid,
        op_add_w, op_sub_w, op_slt, op_sltu, op_nor, op_and, op_or, op_xor,
        op_orn, op_andn, op_sll_w, op_srl_w, op_sra_w,
        op_mul_w, op_mulh_w, op_mulh_wu, op_div_w, op_mod_w, op_div_wu, op_mod_wu,
        op_slli_w, op_srli_w, op_srai_w,
        op_slti, op_sltui, op_addi_w, op_andi, op_ori, op_xori,
        op_lu12i_w, op_pcaddi, op_pcaddu12i,
        op_ld_b, op_ld_h, op_ld_w, op_ld_bu, op_ld_hu, op_st_b, op_st_h, op_st_w,
        op_jirl, op_b, op_bl, op_beq, op_bne, op_blt, op_bge, op_bltu, op_bgeu
    } inst_op_e;

    typedef enum logic [4:0] {
        alu_none, alu_add, alu_sub, alu_slt, alu_sltu,
        alu_nor, alu_and, alu_or, alu_xor, alu_orn, alu_andn,
        alu_sll, alu_srl, alu_sra,
        alu_mul, alu_mulh, alu_mulhu, alu_div, alu_mod, alu_divu, alu_modu,
        alu_lui
    } alu_op_e;

    typedef enum logic [1:0] {
        mem_b,
        mem_h,
        mem_w
    } mem_size_e;

    typedef enum logic [2:0] {
        br_none, br_always, br_eq, br_ne, br_lt, br_ge, br_ltu, br_geu
    } br_cond_e;

    typedef struct packed {
        inst_op_e  op;
        alu_op_e   alu_op;
        logic      src2_imm;
        logic      src1_pc;
        logic      reg_we;
        reg_idx_t  rd;
        reg_idx_t  rj;
        reg_idx_t  rk;
        reg_idx_t  dest;
        logic      mem_rd;
        logic      mem_wr;
        mem_size_e mem_size;
        logic      mem_uns;
        br_cond_e  br_cond;
        logic      br_reg;   // target from rj, jirl
        logic      invalid;
    } dec_ctrl_t;

    typedef struct packed {
        logic [inst_w-1:0] pc;
        dec_ctrl_t         ctrl;
        logic [inst_w-1:0] imm;
    } dec_pkt_t;

    // op_31_26
    localparam logic [5:0] opc6_alu       = 6'h00;
    localparam logic [5:0] opc6_lu12i     = 6'h05;
    localparam logic [5:0] opc6_pcaddi    = 6'h06;
    localparam logic [5:0] opc6_pcaddu12i = 6'h07;
    localparam logic [5:0] opc6_mem       = 6'h0a;
    localparam logic [5:0] opc6_jirl      = 6'h13;
    localparam logic [5:0] opc6_b         = 6'h14;
    localparam logic [5:0] opc6_bl        = 6'h15;
    localparam logic [5:0] opc6_beq       = 6'h16;
    localparam logic [5:0] opc6_bne       = 6'h17;
    localparam logic [5:0] opc6_blt       = 6'h18;
    localparam logic [5:0] opc6_bge       = 6'h19;
    localparam logic [5:0] opc6_bltu      = 6'h1a;
    localparam logic [5:0] opc6_bgeu      = 6'h1b;

    // op_25_22, alu group then memory group
    localparam logic [3:0] opc4_reg   = 4'h0;
    localparam logic [3:0] opc4_shift = 4'h1;
    localparam logic [3:0] opc4_slti  = 4'h8;
    localparam logic [3:0] opc4_sltui = 4'h9;
    localparam logic [3:0] opc4_addi  = 4'ha;
    localparam logic [3:0] opc4_andi  = 4'hd;
    localparam logic [3:0] opc4_ori   = 4'he;
    localparam logic [3:0] opc4_xori  = 4'hf;
    localparam logic [3:0] opc4_ld_b  = 4'h0;
    localparam logic [3:0] opc4_ld_h  = 4'h1;
    localparam logic [3:0] opc4_ld_w  = 4'h2;
    localparam logic [3:0] opc4_st_b  = 4'h4;
    localparam logic [3:0] opc4_st_h  = 4'h5;
    localparam logic [3:0] opc4_st_w  = 4'h6;
    localparam logic [3:0] opc4_ld_bu = 4'h8;
    localparam logic [3:0] opc4_ld_hu = 4'h9;

    // op_21_20
    localparam logic [1:0] opc2_shift = 2'h0;
    localparam logic [1:0] opc2_3r    = 2'h1;
    localparam logic [1:0] opc2_div   = 2'h2;

    // op_19_15
    localparam logic [4:0] opc5_add   = 5'h00;
    localparam logic [4:0] opc5_sub   = 5'h02;
    localparam logic [4:0] opc5_slt   = 5'h04;
    localparam logic [4:0] opc5_sltu  = 5'h05;
    localparam logic [4:0] opc5_nor   = 5'h08;
    localparam logic [4:0] opc5_and   = 5'h09;
    localparam logic [4:0] opc5_or    = 5'h0a;
    localparam logic [4:0] opc5_xor   = 5'h0b;
    localparam logic [4:0] opc5_orn   = 5'h0c;
    localparam logic [4:0] opc5_andn  = 5'h0d;
    localparam logic [4:0] opc5_sll   = 5'h0e;
    localparam logic [4:0] opc5_srl   = 5'h0f;
    localparam logic [4:0] opc5_sra   = 5'h10;
    localparam logic [4:0] opc5_mul   = 5'h18;
    localparam logic [4:0] opc5_mulh  = 5'h19;
    localparam logic [4:0] opc5_mulhu = 5'h1a;
    localparam logic [4:0] opc5_div   = 5'h00;
    localparam logic [4:0] opc5_mod   = 5'h01;
    localparam logic [4:0] opc5_divu  = 5'h02;
    localparam logic [4:0] opc5_modu  = 5'h03;
    localparam logic [4:0] opc5_slli  = 5'h01;
    localparam logic [4:0] opc5_srli  = 5'h09;
    localparam logic [4:0] opc5_srai  = 5'h11;

endpackage

/* inst_match.sv */
// purely combinational; any encoding outside the kept LA32 subset yields op_invalid
`timescale 1ns/1ps

module inst_match import la_decode_pkg::*; (
    input  logic [inst_w-1:0] inst_i,
    output inst_op_e          op_o
);

    logic [63:0] op_31_26_d;
    logic [15:0] op_25_22_d;
    logic [3:0]  op_21_20_d;
    logic [31:0] op_19_15_d;
    logic        grp_3r;
    logic        grp_div;
    logic        grp_shi;
    logic        grp_alu;
    logic        grp_mem;

    // one-hot predecode of each field
    assign op_31_26_d = 64'd1 << inst_i[31:26];
    assign op_25_22_d = 16'd1 << inst_i[25:22];
    assign op_21_20_d = 4'd1 << inst_i[21:20];
    assign op_19_15_d = 32'd1 << inst_i[19:15];

    assign grp_alu = op_31_26_d[opc6_alu];
    assign grp_mem = op_31_26_d[opc6_mem];
    assign grp_3r  = grp_alu & op_25_22_d[opc4_reg] & op_21_20_d[opc2_3r];
    assign grp_div = grp_alu & op_25_22_d[opc4_reg] & op_21_20_d[opc2_div];
    assign grp_shi = grp_alu & op_25_22_d[opc4_shift] & op_21_20_d[opc2_shift];

    // terms are disjoint, so order of the ifs does not matter
    always_comb begin
        op_o = op_invalid;
        if (grp_3r & op_19_15_d[opc5_add])   op_o = op_add_w;
        if (grp_3r & op_19_15_d[opc5_sub])   op_o = op_sub_w;
        if (grp_3r & op_19_15_d[opc5_slt])   op_o = op_slt;
        if (grp_3r & op_19_15_d[opc5_sltu])  op_o = op_sltu;
        if (grp_3r & op_19_15_d[opc5_nor])   op_o = op_nor;
        if (grp_3r & op_19_15_d[opc5_and])   op_o = op_and;
        if (grp_3r & op_19_15_d[opc5_or])    op_o = op_or;
        if (grp_3r & op_19_15_d[opc5_xor])   op_o = op_xor;
        if (grp_3r & op_19_15_d[opc5_orn])   op_o = op_orn;
        if (grp_3r & op_19_15_d[opc5_andn])  op_o = op_andn;
        if (grp_3r & op_19_15_d[opc5_sll])   op_o = op_sll_w;
        if (grp_3r & op_19_15_d[opc5_srl])   op_o = op_srl_w;
        if (grp_3r & op_19_15_d[opc5_sra])   op_o = op_sra_w;
        if (grp_3r & op_19_15_d[opc5_mul])   op_o = op_mul_w;
        if (grp_3r & op_19_15_d[opc5_mulh])  op_o = op_mulh_w;
        if (grp_3r & op_19_15_d[opc5_mulhu]) op_o = op_mulh_wu;
        if (grp_div & op_19_15_d[opc5_div])  op_o = op_div_w;
        if (grp_div & op_19_15_d[opc5_mod])  op_o = op_mod_w;
        if (grp_div & op_19_15_d[opc5_divu]) op_o = op_div_wu;
        if (grp_div & op_19_15_d[opc5_modu]) op_o = op_mod_wu;
        if (grp_shi & op_19_15_d[opc5_slli]) op_o = op_slli_w;
        if (grp_shi & op_19_15_d[opc5_srli]) op_o = op_srli_w;
        if (grp_shi & op_19_15_d[opc5_srai]) op_o = op_srai_w;

        // 12-bit immediate forms, bits 21:10 are payload
        if (grp_alu & op_25_22_d[opc4_slti])  op_o = op_slti;
        if (grp_alu & op_25_22_d[opc4_sltui]) op_o = op_sltui;
        if (grp_alu & op_25_22_d[opc4_addi])  op_o = op_addi_w;
        if (grp_alu & op_25_22_d[opc4_andi])  op_o = op_andi;
        if (grp_alu & op_25_22_d[opc4_ori])   op_o = op_ori;
        if (grp_alu & op_25_22_d[opc4_xori])  op_o = op_xori;

        if (op_31_26_d[opc6_lu12i] & ~inst_i[25])     op_o = op_lu12i_w;
        if (op_31_26_d[opc6_pcaddi] & ~inst_i[25])    op_o = op_pcaddi;
        if (op_31_26_d[opc6_pcaddu12i] & ~inst_i[25]) op_o = op_pcaddu12i;

        if (grp_mem & op_25_22_d[opc4_ld_b])  op_o = op_ld_b;
        if (grp_mem & op_25_22_d[opc4_ld_h])  op_o = op_ld_h;
        if (grp_mem & op_25_22_d[opc4_ld_w])  op_o = op_ld_w;
        if (grp_mem & op_25_22_d[opc4_ld_bu]) op_o = op_ld_bu;
        if (grp_mem & op_25_22_d[opc4_ld_hu]) op_o = op_ld_hu;
        if (grp_mem & op_25_22_d[opc4_st_b])  op_o = op_st_b;
        if (grp_mem & op_25_22_d[opc4_st_h])  op_o = op_st_h;
        if (grp_mem & op_25_22_d[opc4_st_w])  op_o = op_st_w;

        if (op_31_26_d[opc6_jirl]) op_o = op_jirl;
        if (op_31_26_d[opc6_b])    op_o = op_b;
        if (op_31_26_d[opc6_bl])   op_o = op_bl;
        if (op_31_26_d[opc6_beq])  op_o = op_beq;
        if (op_31_26_d[opc6_bne])  op_o = op_bne;
        if (op_31_26_d[opc6_blt])  op_o = op_blt;
        if (op_31_26_d[opc6_bge])  op_o = op_bge;
        if (op_31_26_d[opc6_bltu]) op_o = op_bltu;
        if (op_31_26_d[opc6_bgeu]) op_o = op_bgeu;
    end

endmodule

/* ctrl_encode.sv */
// combinational; jirl is marked br_always with br_reg, immediate operand only via imm_gen
`timescale 1ns/1ps

module ctrl_encode import la_decode_pkg::*; (
    input  logic [inst_w-1:0] inst_i,
    input  inst_op_e          op_i,
    output dec_ctrl_t         ctrl_o
);

    always_comb begin
        ctrl_o.op = op_i;
        ctrl_o.rd = inst_i[4:0];
        ctrl_o.rj = inst_i[9:5];
        ctrl_o.rk = inst_i[14:10];   // stores and branches use rd as a source
        ctrl_o.dest = (op_i == op_bl) ? 5'd1 : inst_i[4:0];
        ctrl_o.invalid = (op_i == op_invalid);

        unique case (op_i)
            op_add_w, op_addi_w:  ctrl_o.alu_op = alu_add;
            op_sub_w:             ctrl_o.alu_op = alu_sub;
            op_slt, op_slti:      ctrl_o.alu_op = alu_slt;
            op_sltu, op_sltui:    ctrl_o.alu_op = alu_sltu;
            op_nor:               ctrl_o.alu_op = alu_nor;
            op_and, op_andi:      ctrl_o.alu_op = alu_and;
            op_or, op_ori:        ctrl_o.alu_op = alu_or;
            op_xor, op_xori:      ctrl_o.alu_op = alu_xor;
            op_orn:               ctrl_o.alu_op = alu_orn;
            op_andn:              ctrl_o.alu_op = alu_andn;
            op_sll_w, op_slli_w:  ctrl_o.alu_op = alu_sll;
            op_srl_w, op_srli_w:  ctrl_o.alu_op = alu_srl;
            op_sra_w, op_srai_w:  ctrl_o.alu_op = alu_sra;
            op_mul_w:             ctrl_o.alu_op = alu_mul;
            op_mulh_w:            ctrl_o.alu_op = alu_mulh;
            op_mulh_wu:           ctrl_o.alu_op = alu_mulhu;
            op_div_w:             ctrl_o.alu_op = alu_div;
            op_mod_w:             ctrl_o.alu_op = alu_mod;
            op_div_wu:            ctrl_o.alu_op = alu_divu;
            op_mod_wu:            ctrl_o.alu_op = alu_modu;
            op_lu12i_w:           ctrl_o.alu_op = alu_lui;
            op_pcaddi, op_pcaddu12i, op_jirl,
            op_ld_b, op_ld_h, op_ld_w, op_ld_bu, op_ld_hu,
            op_st_b, op_st_h, op_st_w: ctrl_o.alu_op = alu_add;   // address or target sum
            default:              ctrl_o.alu_op = alu_none;
        endcase

        ctrl_o.src2_imm = op_i inside {op_slli_w, op_srli_w, op_srai_w, op_slti, op_sltui,
                                       op_addi_w, op_andi, op_ori, op_xori, op_lu12i_w,
                                       op_pcaddi, op_pcaddu12i, op_jirl,
                                       op_ld_b, op_ld_h, op_ld_w, op_ld_bu, op_ld_hu,
                                       op_st_b, op_st_h, op_st_w};
        ctrl_o.src1_pc = op_i inside {op_pcaddi, op_pcaddu12i};
        ctrl_o.reg_we = !(op_i inside {op_invalid, op_st_b, op_st_h, op_st_w, op_b,
                                       op_beq, op_bne, op_blt, op_bge, op_bltu, op_bgeu});

        ctrl_o.mem_rd = op_i inside {op_ld_b, op_ld_h, op_ld_w, op_ld_bu, op_ld_hu};
        ctrl_o.mem_wr = op_i inside {op_st_b, op_st_h, op_st_w};
        ctrl_o.mem_uns = op_i inside {op_ld_bu, op_ld_hu};
        unique case (op_i)
            op_ld_b, op_ld_bu, op_st_b: ctrl_o.mem_size = mem_b;
            op_ld_h, op_ld_hu, op_st_h: ctrl_o.mem_size = mem_h;
            default:                    ctrl_o.mem_size = mem_w;
        endcase

        unique case (op_i)
            op_jirl, op_b, op_bl: ctrl_o.br_cond = br_always;
            op_beq:               ctrl_o.br_cond = br_eq;
            op_bne:               ctrl_o.br_cond = br_ne;
            op_blt:               ctrl_o.br_cond = br_lt;
            op_bge:               ctrl_o.br_cond = br_ge;
            op_bltu:              ctrl_o.br_cond = br_ltu;
            op_bgeu:              ctrl_o.br_cond = br_geu;
            default:              ctrl_o.br_cond = br_none;
        endcase
        ctrl_o.br_reg = (op_i == op_jirl);
    end

endmodule

/* imm_gen.sv */
// combinational; shifts of offsets and si20 are applied here, so the ALU adds them as is
`timescale 1ns/1ps

module imm_gen import la_decode_pkg::*; (
    input  logic [inst_w-1:0] inst_i,
    input  inst_op_e          op_i,
    output logic [inst_w-1:0] imm_o
);

    logic [inst_w-1:0] si12;
    logic [inst_w-1:0] ui12;
    logic [inst_w-1:0] ui5;
    logic [inst_w-1:0] si20_hi;
    logic [inst_w-1:0] si20_w;
    logic [inst_w-1:0] offs16;
    logic [inst_w-1:0] offs26;

    assign si12    = {{20{inst_i[21]}}, inst_i[21:10]};
    assign ui12    = {20'd0, inst_i[21:10]};
    assign ui5     = {27'd0, inst_i[14:10]};
    assign si20_hi = {inst_i[24:5], 12'd0};
    assign si20_w  = {{10{inst_i[24]}}, inst_i[24:5], 2'b00};  // pcaddi word offset
    assign offs16  = {{14{inst_i[25]}}, inst_i[25:10], 2'b00};
    assign offs26  = {{4{inst_i[9]}}, inst_i[9:0], inst_i[25:10], 2'b00}; // high part in 9:0

    always_comb begin
        unique case (op_i)
            op_slti, op_sltui, op_addi_w,
            op_ld_b, op_ld_h, op_ld_w, op_ld_bu, op_ld_hu,
            op_st_b, op_st_h, op_st_w:      imm_o = si12;
            op_andi, op_ori, op_xori:       imm_o = ui12;
            op_slli_w, op_srli_w, op_srai_w: imm_o = ui5;
            op_lu12i_w, op_pcaddu12i:       imm_o = si20_hi;
            op_pcaddi:                      imm_o = si20_w;
            op_jirl, op_beq, op_bne, op_blt,
            op_bge, op_bltu, op_bgeu:       imm_o = offs16;
            op_b, op_bl:                    imm_o = offs26;
            default:                        imm_o = '0;
        endcase
    end

endmodule

/* decode_ctrl.sv */
// one-entry output register; full rate needs out_ready_i high in the same cycle
`timescale 1ns/1ps

module decode_ctrl import la_decode_pkg::*; (
    input  logic              clk,
    input  logic              rst_n_i,
    input  logic              in_valid_i,
    output logic              in_ready_o,
    input  logic [inst_w-1:0] pc_i,
    input  dec_ctrl_t         ctrl_i,
    input  logic [inst_w-1:0] imm_i,
    output logic              out_valid_o,
    input  logic              out_ready_i,
    output dec_pkt_t          out_pkt_o
);

    logic     valid_q;
    logic     take;
    dec_pkt_t pkt_q;

    // free when empty or when the held packet leaves this cycle
    assign in_ready_o = ~valid_q | out_ready_i;
    assign take       = in_valid_i & in_ready_o;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q <= 1'b0;
        end else if (in_ready_o) begin
            valid_q <= in_valid_i;   // refill or drain
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            pkt_q.pc   <= pc_i;
            pkt_q.ctrl <= ctrl_i;
            pkt_q.imm  <= imm_i;
        end
    end

    assign out_valid_o = valid_q;
    assign out_pkt_o   = pkt_q;

endmodule

/* decode_stage.sv */
// decode stage top; one cycle from accepted fetch packet to out_valid_o, no flush input
`timescale 1ns/1ps

module decode_stage import la_decode_pkg::*; (
    input  logic       clk,
    input  logic       rst_n_i,
    input  logic       in_valid_i,
    output logic       in_ready_o,
    input  fetch_pkt_t in_pkt_i,
    output logic       out_valid_o,
    input  logic       out_ready_i,
    output dec_pkt_t   out_pkt_o
);

    inst_op_e          op;
    dec_ctrl_t         ctrl;
    logic [inst_w-1:0] imm;

    inst_match u_match (
        .inst_i (in_pkt_i.inst),
        .op_o   (op)
    );

    ctrl_encode u_encode (
        .inst_i (in_pkt_i.inst),
        .op_i   (op),
        .ctrl_o (ctrl)
    );

    imm_gen u_imm (
        .inst_i (in_pkt_i.inst),
        .op_i   (op),
        .imm_o  (imm)
    );

    decode_ctrl u_ctrl (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .in_valid_i  (in_valid_i),
        .in_ready_o  (in_ready_o),
        .pc_i        (in_pkt_i.pc),
        .ctrl_i      (ctrl),
        .imm_i       (imm),
        .out_valid_o (out_valid_o),
        .out_ready_i (out_ready_i),
        .out_pkt_o   (out_pkt_o)
    );

endmodule

/* tb_decode_tasks.svh */
// included inside tb_decode_stage only; uses its clk, DUT signals, queue and counters

// fixed bits of an encoding, returned as {value, mask}
function automatic logic [63:0] pfx(int width, logic [31:0] code);
    logic [31:0] v;
    logic [31:0] m;
    v = code << (32 - width);
    m = 32'hffff_ffff << (32 - width);
    return {v, m};
endfunction

function automatic logic [63:0] pattern(inst_op_e op);
    case (op)
        op_add_w:     return pfx(17, 32'h20);
        op_sub_w:     return pfx(17, 32'h22);
        op_slt:       return pfx(17, 32'h24);
        op_sltu:      return pfx(17, 32'h25);
        op_nor:       return pfx(17, 32'h28);
        op_and:       return pfx(17, 32'h29);
        op_or:        return pfx(17, 32'h2a);
        op_xor:       return pfx(17, 32'h2b);
        op_orn:       return pfx(17, 32'h2c);
        op_andn:      return pfx(17, 32'h2d);
        op_sll_w:     return pfx(17, 32'h2e);
        op_srl_w:     return pfx(17, 32'h2f);
        op_sra_w:     return pfx(17, 32'h30);
        op_mul_w:     return pfx(17, 32'h38);
        op_mulh_w:    return pfx(17, 32'h39);
        op_mulh_wu:   return pfx(17, 32'h3a);
        op_div_w:     return pfx(17, 32'h40);
        op_mod_w:     return pfx(17, 32'h41);
        op_div_wu:    return pfx(17, 32'h42);
        op_mod_wu:    return pfx(17, 32'h43);
        op_slli_w:    return pfx(17, 32'h81);
        op_srli_w:    return pfx(17, 32'h89);
        op_srai_w:    return pfx(17, 32'h91);
        op_slti:      return pfx(10, 32'h008);
        op_sltui:     return pfx(10, 32'h009);
        op_addi_w:    return pfx(10, 32'h00a);
        op_andi:      return pfx(10, 32'h00d);
        op_ori:       return pfx(10, 32'h00e);
        op_xori:      return pfx(10, 32'h00f);
        op_lu12i_w:   return pfx(7, 32'h0a);
        op_pcaddi:    return pfx(7, 32'h0c);
        op_pcaddu12i: return pfx(7, 32'h0e);
        op_ld_b:      return pfx(10, 32'h0a0);
        op_ld_h:      return pfx(10, 32'h0a1);
        op_ld_w:      return pfx(10, 32'h0a2);
        op_st_b:      return pfx(10, 32'h0a4);
        op_st_h:      return pfx(10, 32'h0a5);
        op_st_w:      return pfx(10, 32'h0a6);
        op_ld_bu:     return pfx(10, 32'h0a8);
        op_ld_hu:     return pfx(10, 32'h0a9);
        op_jirl:      return pfx(6, 32'h13);
        op_b:         return pfx(6, 32'h14);
        op_bl:        return pfx(6, 32'h15);
        op_beq:       return pfx(6, 32'h16);
        op_bne:       return pfx(6, 32'h17);
        op_blt:       return pfx(6, 32'h18);
        op_bge:       return pfx(6, 32'h19);
        op_bltu:      return pfx(6, 32'h1a);
        op_bgeu:      return pfx(6, 32'h1b);
        default:      return 64'hffff_ffff_0000_0000;  // matches no word
    endcase
endfunction

function automatic logic [31:0] make_word(inst_op_e op, logic [31:0] rnd);
    logic [63:0] p;
    p = pattern(op);
    return p[63:32] | (rnd & ~p[31:0]);
endfunction

function automatic inst_op_e ref_op(logic [31:0] w);
    logic [63:0] p;
    for (int i = 1; i <= 49; i++) begin
        p = pattern(inst_op_e'(i));
        if ((w & p[31:0]) == p[63:32]) return inst_op_e'(i);
    end
    return op_invalid;
endfunction

function automatic dec_ctrl_t ref_ctrl(logic [31:0] w);
    dec_ctrl_t c;
    inst_op_e  op;
    op = ref_op(w);
    c = '0;
    c.op = op;
    c.rd = w[4:0];
    c.rj = w[9:5];
    c.rk = w[14:10];
    c.dest = (op == op_bl) ? 5'd1 : w[4:0];
    c.invalid = (op == op_invalid);
    case (op)
        op_sub_w:                       c.alu_op = alu_sub;
        op_slt, op_slti:                c.alu_op = alu_slt;
        op_sltu, op_sltui:              c.alu_op = alu_sltu;
        op_nor:                         c.alu_op = alu_nor;
        op_and, op_andi:                c.alu_op = alu_and;
        op_or, op_ori:                  c.alu_op = alu_or;
        op_xor, op_xori:                c.alu_op = alu_xor;
        op_orn:                         c.alu_op = alu_orn;
        op_andn:                        c.alu_op = alu_andn;
        op_sll_w, op_slli_w:            c.alu_op = alu_sll;
        op_srl_w, op_srli_w:            c.alu_op = alu_srl;
        op_sra_w, op_srai_w:            c.alu_op = alu_sra;
        op_mul_w:                       c.alu_op = alu_mul;
        op_mulh_w:                      c.alu_op = alu_mulh;
        op_mulh_wu:                     c.alu_op = alu_mulhu;
        op_div_w:                       c.alu_op = alu_div;
        op_mod_w:                       c.alu_op = alu_mod;
        op_div_wu:                      c.alu_op = alu_divu;
        op_mod_wu:                      c.alu_op = alu_modu;
        op_lu12i_w:                     c.alu_op = alu_lui;
        op_add_w, op_addi_w, op_pcaddi,
        op_pcaddu12i, op_jirl:          c.alu_op = alu_add;
        default:                        c.alu_op = alu_none;
    endcase
    if (op >= op_ld_b && op <= op_st_w) c.alu_op = alu_add;
    c.src2_imm = (op >= op_slli_w && op <= op_st_w) || op == op_jirl;
    c.src1_pc = (op == op_pcaddi) || (op == op_pcaddu12i);
    c.mem_rd = (op >= op_ld_b && op <= op_ld_hu);
    c.mem_wr = (op >= op_st_b && op <= op_st_w);
    c.mem_uns = (op == op_ld_bu) || (op == op_ld_hu);
    if (op == op_ld_b || op == op_ld_bu || op == op_st_b) c.mem_size = mem_b;
    else if (op == op_ld_h || op == op_ld_hu || op == op_st_h) c.mem_size = mem_h;
    else c.mem_size = mem_w;
    case (op)
        op_jirl, op_b, op_bl: c.br_cond = br_always;
        op_beq:               c.br_cond = br_eq;
        op_bne:               c.br_cond = br_ne;
        op_blt:               c.br_cond = br_lt;
        op_bge:               c.br_cond = br_ge;
        op_bltu:              c.br_cond = br_ltu;
        op_bgeu:              c.br_cond = br_geu;
        default:              c.br_cond = br_none;
    endcase
    c.br_reg = (op == op_jirl);
    c.reg_we = !(c.invalid || c.mem_wr || op == op_b || op >= op_beq);
    return c;
endfunction

function automatic logic [31:0] ref_imm(logic [31:0] w);
    inst_op_e op;
    op = ref_op(w);
    if (op inside {op_slti, op_sltui, op_addi_w}) return 32'($signed(w[21:10]));
    if (op >= op_ld_b && op <= op_st_w) return 32'($signed(w[21:10]));
    if (op inside {op_andi, op_ori, op_xori}) return 32'(w[21:10]);
    if (op inside {op_slli_w, op_srli_w, op_srai_w}) return 32'(w[14:10]);
    if (op inside {op_lu12i_w, op_pcaddu12i}) return {w[24:5], 12'h000};
    if (op == op_pcaddi) return 32'($signed({w[24:5], 2'b00}));
    if (op == op_jirl || op >= op_beq) return 32'($signed({w[25:10], 2'b00}));
    if (op == op_b || op == op_bl) return 32'($signed({w[9:0], w[25:10], 2'b00}));
    return 32'h0;
endfunction

function logic [31:0] xorshift32();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
endfunction

task automatic check_bit(input string name, input logic exp, input logic act);
    n_checks++;
    if (exp !== act) begin
        $display("FAIL t=%0t %s exp=%b act=%b", $time, name, exp, act);
        errors++;
    end
endtask

task automatic check_imm(input string name, input logic [31:0] exp, input logic [31:0] act);
    n_checks++;
    if (exp !== act) begin
        $display("FAIL t=%0t %s exp=%h act=%h", $time, name, exp, act);
        errors++;
    end
endtask

task automatic check_ctrl(input string name, input dec_ctrl_t exp, input dec_ctrl_t act);
    n_checks++;
    if (exp !== act) begin
        $display("FAIL t=%0t %s exp=%h (%s) act=%h (%s)", $time, name, exp,
                 exp.op.name(), act, act.op.name());
        errors++;
    end
endtask

// drive one word on the falling edge, return on the accepting rising edge
task automatic send(input logic [31:0] w);
    dec_pkt_t exp;
    @(negedge clk);
    in_valid_i = 1'b1;
    in_pkt_i.pc = pc_next;
    in_pkt_i.inst = w;
    @(posedge clk);
    while (!in_ready_o) begin
        stalls++;
        @(posedge clk);
    end
    exp.pc = pc_next;
    exp.ctrl = ref_ctrl(w);
    exp.imm = ref_imm(w);
    exp_q.push_back(exp);
    last_sent = exp;
    pc_next = pc_next + 32'd4;
endtask

task automatic idle();
    @(negedge clk);
    in_valid_i = 1'b0;
endtask

task automatic drain();
    idle();
    while (exp_q.size() != 0) begin
        @(posedge clk);
    end
    repeat (2) @(negedge clk);
endtask

/* tb_decode_stage.sv */
// directed testbench for decode_stage; needs a simulator with delay support in tasks
`timescale 1ns/1ps

module tb_decode_stage import la_decode_pkg::*; ();

    localparam int n_txn       = 194;   // sum over all tests below
    localparam int watchdog_ns = (n_txn * 20 + 16 + 8) * 10;

    logic       clk = 1'b0;
    logic       rst_n_i;
    logic       in_valid_i;
    logic       in_ready_o;
    fetch_pkt_t in_pkt_i;
    logic       out_valid_o;
    logic       out_ready_i;
    dec_pkt_t   out_pkt_o;

    dec_pkt_t    exp_q[$];
    dec_pkt_t    last_sent;
    logic [31:0] rng_state = 32'h723d_7bda;
    logic [31:0] pc_next = 32'h1c00_0000;
    int          errors = 0;
    int          n_checks = 0;
    int          n_tests = 0;
    int          stalls = 0;

    `include "tb_decode_tasks.svh"

    decode_stage uut (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .in_valid_i  (in_valid_i),
        .in_ready_o  (in_ready_o),
        .in_pkt_i    (in_pkt_i),
        .out_valid_o (out_valid_o),
        .out_ready_i (out_ready_i),
        .out_pkt_o   (out_pkt_o)
    );

    always #5 clk = ~clk;

    // scoreboard, in order
    always @(posedge clk) begin : out_monitor
        dec_pkt_t exp;
        if (rst_n_i && out_valid_o && out_ready_i) begin
            if (exp_q.size() == 0) begin
                $display("output transfer at %0t when no packet was expected", $time);
                errors++;
            end else begin
                exp = exp_q.pop_front();
                check_imm("out_pkt_o.pc", exp.pc, out_pkt_o.pc);
                check_ctrl("out_pkt_o.ctrl", exp.ctrl, out_pkt_o.ctrl);
                check_imm("out_pkt_o.imm", exp.imm, out_pkt_o.imm);
            end
        end
    end

    initial begin : watchdog
        #(watchdog_ns);
        $display("timeout: the test sequence did not finish in the allowed time");
        $display("RESULT: FAIL");
        $finish;
    end

    task automatic report(input string name, input int e0);
        n_tests++;
        $display("test %s done, %0d errors", name, errors - e0);
    endtask

    task automatic run_ops(input int lo, input int hi, input int reps);
        for (int i = lo; i <= hi; i++) begin
            for (int r = 0; r < reps; r++) begin
                send(make_word(inst_op_e'(i), xorshift32()));
            end
        end
        drain();
    endtask

    task automatic test_reset();
        int e0;
        e0 = errors;
        repeat (16) begin
            @(negedge clk);
            check_bit("out_valid_o", 1'b0, out_valid_o);
            check_bit("in_ready_o", 1'b1, in_ready_o);
        end
        rst_n_i = 1'b1;
        @(negedge clk);
        check_bit("out_valid_o", 1'b0, out_valid_o);
        check_bit("in_ready_o", 1'b1, in_ready_o);
        out_ready_i = 1'b1;
        send(make_word(op_add_w, xorshift32()));
        idle();
        check_bit("out_valid_o", 1'b1, out_valid_o);
        drain();
        report("reset", e0);
    endtask

    task automatic test_reg_alu();
        int e0;
        e0 = errors;
        run_ops(op_add_w, op_mod_wu, 2);
        report("reg_alu_muldiv", e0);
    endtask

    task automatic test_imm_formats();
        int e0;
        e0 = errors;
        run_ops(op_slli_w, op_pcaddu12i, 4);
        report("imm_formats", e0);
    endtask

    task automatic test_mem();
        int e0;
        e0 = errors;
        run_ops(op_ld_b, op_st_w, 4);
        report("loads_stores", e0);
    endtask

    task automatic test_branch_invalid();
        int          e0;
        int          found;
        logic [31:0] w;
        e0 = errors;
        run_ops(op_jirl, op_bgeu, 4);
        send(32'h0400_0c05);   // csrrd
        send(32'h0648_2800);   // tlbsrch
        send(32'h3872_0000);   // dbar 0
        send(32'h002b_0000);   // syscall 0
        send(32'h0000_0000);
        found = 0;
        while (found < 10) begin
            w = xorshift32();
            if (ref_op(w) == op_invalid) begin
                send(w);
                found++;
            end
        end
        drain();
        report("branches_invalid", e0);
    endtask

    task automatic test_backpressure();
        int       e0;
        int       s0;
        dec_pkt_t held;
        e0 = errors;
        @(negedge clk);
        out_ready_i = 1'b0;
        send(make_word(op_ld_w, xorshift32()));
        held = last_sent;
        fork
            send(make_word(op_bl, xorshift32()));
            begin
                repeat (4) begin
                    @(negedge clk);
                    check_bit("in_ready_o", 1'b0, in_ready_o);
                    check_bit("out_valid_o", 1'b1, out_valid_o);
                    check_imm("out_pkt_o.pc", held.pc, out_pkt_o.pc);
                    check_ctrl("out_pkt_o.ctrl", held.ctrl, out_pkt_o.ctrl);
                    check_imm("out_pkt_o.imm", held.imm, out_pkt_o.imm);
                end
                out_ready_i = 1'b1;
            end
        join
        s0 = stalls;
        repeat (20) begin
            send(make_word(inst_op_e'(1 + xorshift32() % 49), xorshift32()));
        end
        check_bit("in_ready_o at full rate", 1'b1, stalls == s0);
        drain();
        report("backpressure_stream", e0);
    endtask

    initial begin : main
        rst_n_i = 1'b0;
        in_valid_i = 1'b0;
        in_pkt_i = '0;
        out_ready_i = 1'b0;   // low so in_ready_o reflects the empty register
        test_reset();
        test_reg_alu();
        test_imm_formats();
        test_mem();
        test_branch_invalid();
        test_backpressure();
        $display("tests %0d, checks %0d, errors %0d", n_tests, n_checks, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* files.f */
+incdir+.
la_decode_pkg.sv
inst_match.sv
ctrl_encode.sv
imm_gen.sv
decode_ctrl.sv
decode_stage.sv
tb_decode_stage.sv

/* Makefile */
VERILATOR ?= verilator
FLAGS     := --binary --timing -j 0
LINTFLAGS := --lint-only --timing
TOP       := tb_decode_stage
FILELIST  := files.f
SIM       := obj_dir/V$(TOP)

.PHONY: run build lint clean

run: build
	@out=$$(./$(SIM)); \
	echo "$$out"; \
	echo "$$out" | grep -q "RESULT: PASS"

build:
	$(VERILATOR) $(FLAGS) -f $(FILELIST) --top-module $(TOP)

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module decode_stage
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf obj_dir
